// File: files.f
+incdir+include
hw/mlpPkg.sv
hw/mlpNeuron.sv
hw/mlpLayer.sv
hw/mlpArgmax.sv
hw/mlpTop.sv
verif/mlpTb.sv

// File: hw/mlpArgmax.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_macros.svh"

module mlpArgmax
	import mlpPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic scoreValid,
	input  scoreVec_t scoreAct,
	output logic outValid,
	output scoreVec_t scores,
	output classIdx_t classIdx
);

	classIdx_t bestIdx;
	activation_t bestScore;

	// Strict compare keeps the lowest index on a tie
	always_comb
	begin
		bestIdx = '0;
		bestScore = scoreAct[0];
		for (int i = 1; i < `NUM_OUTPUTS; i++)
		begin
			if (scoreAct[i] > bestScore)
			begin
				bestIdx = classIdx_t'(i);
				bestScore = scoreAct[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			scores <= '0;
			classIdx <= '0;
		end
		else
		begin
			outValid <= scoreValid;
			scores <= scoreAct; // Scores travel with the index
			classIdx <= bestIdx;
		end
	end

	classInRange: assert property (@(posedge clk) disable iff (reset)
		outValid |-> (classIdx < `NUM_OUTPUTS));

endmodule

`default_nettype wire

// File: hw/mlpLayer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_macros.svh"

module mlpLayer
	import mlpPkg::*;
#(
	parameter int NUM_IN = `NUM_INPUTS,
	parameter int NUM_OUT = `NUM_HIDDEN,
	parameter activation_t [NUM_OUT-1:0][NUM_IN-1:0] WEIGHTS = '0,
	parameter activation_t [NUM_OUT-1:0] BIAS = '0
)
(
	input  logic clk,
	input  logic reset,
	input  logic validIn,
	input  activation_t [NUM_IN-1:0] inputs,
	output logic validOut,
	output activation_t [NUM_OUT-1:0] acts
);

	logic [`PIPE_DEPTH-1:0] validPipe; // Bit 0 is the newest strobe

	genvar n;

	generate
		for (n = 0; n < NUM_OUT; n++)
		begin : neuronGen
			mlpNeuron #(
				.NUM_IN  (NUM_IN),
				.WEIGHTS (WEIGHTS[n]),
				.BIAS    (BIAS[n])
			) neuron (
				.clk    (clk),
				.reset  (reset),
				.inputs (inputs),
				.act    (acts[n])
			);
		end
	endgenerate

	// Same depth as the neuron pipeline
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[`PIPE_DEPTH-2:0], validIn};
	end

	assign validOut = validPipe[`PIPE_DEPTH-1];

	// Only checked once the whole delay line has been filled since reset
	validAligned: assert property (@(posedge clk)
		(!reset) [*(`PIPE_DEPTH + 1)] |-> (validOut == $past(validIn, `PIPE_DEPTH)));

endmodule

`default_nettype wire

// File: hw/mlpNeuron.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_macros.svh"

module mlpNeuron
	import mlpPkg::*;
#(
	parameter int NUM_IN = `NUM_INPUTS,
	parameter activation_t [NUM_IN-1:0] WEIGHTS = '0,
	parameter activation_t BIAS = '0
)
(
	input  logic clk,
	input  logic reset,
	input  activation_t [NUM_IN-1:0] inputs,
	output activation_t act
);

	localparam sum_t ACT_CLAMP = sum_t'((1 << (`ACT_WIDTH - 1)) - 1); // Largest positive activation

	activation_t [NUM_IN-1:0] inReg;
	sum_t macSum;
	sum_t sumReg;
	sum_t shiftedSum;
	activation_t actNext;

	// Stage 1
	always_ff @(posedge clk)
	begin
		if (reset)
			inReg <= '0;
		else
			inReg <= inputs;
	end

	// Products are widened before the multiply so the sum cannot wrap
	always_comb
	begin
		macSum = sum_t'(BIAS);
		for (int i = 0; i < NUM_IN; i++)
			macSum = macSum + sum_t'(inReg[i]) * sum_t'(WEIGHTS[i]);
	end

	// Stage 2
	always_ff @(posedge clk)
	begin
		if (reset)
			sumReg <= '0;
		else
			sumReg <= macSum;
	end

	assign shiftedSum = sumReg >>> `ACT_SHIFT;

	// Rectify on the real sign bit, then requantize back to activation width
	always_comb
	begin
		if (sumReg[`SUM_WIDTH-1])
			actNext = '0;
		else if (shiftedSum > ACT_CLAMP)
			actNext = activation_t'(ACT_CLAMP);
		else
			actNext = activation_t'(shiftedSum);
	end

	// Stage 3
	always_ff @(posedge clk)
	begin
		if (reset)
			act <= '0;
		else
			act <= actNext;
	end

	actNonNegative: assert property (@(posedge clk) disable iff (reset)
		!act[`ACT_WIDTH-1]);

endmodule

`default_nettype wire

// File: hw/mlpPkg.sv
`default_nettype none

`include "mlp_macros.svh"

package mlpPkg;

	typedef logic signed [`ACT_WIDTH-1:0] activation_t;
	typedef logic signed [`SUM_WIDTH-1:0] sum_t;

	typedef activation_t [`NUM_INPUTS-1:0] featureVec_t;
	typedef activation_t [`NUM_HIDDEN-1:0] hiddenVec_t;
	typedef activation_t [`NUM_OUTPUTS-1:0] scoreVec_t;

	typedef logic [`CLASS_WIDTH-1:0] classIdx_t;

	// Each row is written from input 14 down to input 0, and the rows from the last one down
	parameter activation_t [`NUM_HIDDEN-1:0][`NUM_INPUTS-1:0] HIDDEN_WEIGHTS = '{
		'{ 8'sd10, -8'sd19,  8'sd40, -8'sd27, -8'sd8,   8'sd28, -8'sd17,  8'sd4,
		   8'sd35, -8'sd22,  8'sd19, -8'sd30,  8'sd8,  -8'sd15,  8'sd25},
		'{ 8'sd21, -8'sd6,  -8'sd12,  8'sd50, -8'sd25,  8'sd3,   8'sd18, -8'sd40,
		   8'sd27,  8'sd6,  -8'sd33,  8'sd14, -8'sd9,   8'sd41, -8'sd20},
		'{-8'sd14,  8'sd30,  8'sd8,  -8'sd11,  8'sd22, -8'sd36,  8'sd17,  8'sd9,
		  -8'sd28,  8'sd44,  8'sd5,  -8'sd19,  8'sd33, -8'sd7,   8'sd12},
		'{-8'sd3,   8'sd111, -8'sd49, 8'sd35,  8'sd0,   8'sd25, -8'sd45,  8'sd59,
		   8'sd16, -8'sd24,  8'sd83, -8'sd45,  8'sd40,  8'sd16, -8'sd38}
	};

	// Neuron 3 down to neuron 0
	parameter activation_t [`NUM_HIDDEN-1:0] HIDDEN_BIAS = '{
		-8'sd3,
		8'sd12,
		-8'sd5,
		8'sd7
	};

	// Class 2 row first; within a row, hidden neuron 3 first
	parameter activation_t [`NUM_OUTPUTS-1:0][`NUM_HIDDEN-1:0] OUTPUT_WEIGHTS = '{
		'{ 8'sd42, -8'sd30,  8'sd15,  8'sd10},
		'{ 8'sd27, -8'sd25,  8'sd38, -8'sd18},
		'{-8'sd12,  8'sd30, -8'sd20,  8'sd45}
	};

	parameter activation_t [`NUM_OUTPUTS-1:0] OUTPUT_BIAS = '{
		8'sd6,
		-8'sd2,
		8'sd4
	};

endpackage

`default_nettype wire

// File: hw/mlpTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_macros.svh"

module mlpTop
	import mlpPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  featureVec_t features,
	output logic outValid,
	output scoreVec_t scores,
	output classIdx_t classIdx
);

	hiddenVec_t hiddenAct;
	logic hiddenValid;
	scoreVec_t scoreAct;
	logic scoreValid;

	// Features to hidden activations, 3 cycles
	mlpLayer #(
		.NUM_IN  (`NUM_INPUTS),
		.NUM_OUT (`NUM_HIDDEN),
		.WEIGHTS (HIDDEN_WEIGHTS),
		.BIAS    (HIDDEN_BIAS)
	) hiddenLayer (
		.clk      (clk),
		.reset    (reset),
		.validIn  (inValid),
		.inputs   (features),
		.validOut (hiddenValid),
		.acts     (hiddenAct)
	);

	// Hidden activations to class scores, 3 more cycles
	mlpLayer #(
		.NUM_IN  (`NUM_HIDDEN),
		.NUM_OUT (`NUM_OUTPUTS),
		.WEIGHTS (OUTPUT_WEIGHTS),
		.BIAS    (OUTPUT_BIAS)
	) outputLayer (
		.clk      (clk),
		.reset    (reset),
		.validIn  (hiddenValid),
		.inputs   (hiddenAct),
		.validOut (scoreValid),
		.acts     (scoreAct)
	);

	mlpArgmax argmax (
		.clk        (clk),
		.reset      (reset),
		.scoreValid (scoreValid),
		.scoreAct   (scoreAct),
		.outValid   (outValid),
		.scores     (scores),
		.classIdx   (classIdx)
	);

endmodule

`default_nettype wire

// File: include/mlp_macros.svh
`ifndef MLP_MACROS_SVH
`define MLP_MACROS_SVH

// Network shape
`define NUM_INPUTS 15
`define NUM_HIDDEN 4
`define NUM_OUTPUTS 3

// Activations and weights share one signed width
`define ACT_WIDTH 8

// Holds 15 full-scale products plus the bias with headroom
`define SUM_WIDTH 20

// A rectified sum is shifted right by this much, then clamped to 127
`define ACT_SHIFT 6

// Input register, sum register, activation register
`define PIPE_DEPTH 3

`define CLASS_WIDTH 2

`endif

// File: run.sh
#!/bin/sh
# Builds the MLP testbench with Verilator, runs it, and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module mlpTb --Mdir obj_dir -o mlpSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mlpSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^sim passed$" sim.log; then
	exit 0
else
	echo "Pass line not found in sim.log"
	exit 1
fi

// File: verif/mlpTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_macros.svh"

module mlpTb
	import mlpPkg::*;
;

	localparam int LATENCY = 2 * `PIPE_DEPTH + 1; // Two layers plus the argmax register
	localparam int TIMEOUT_CYCLES = 2000; // The tests need about 170 cycles

	logic clk;
	logic reset;
	logic inValid;
	featureVec_t features;
	logic outValid;
	scoreVec_t scores;
	classIdx_t classIdx;

	scoreVec_t expScoresQ[$];
	classIdx_t expClassQ[$];
	int expCycleQ[$];

	int cycleCount = 0;
	int errorCount = 0;
	int testErrors;
	int passCount = 0;
	int failCount = 0;
	int pulseCount;
	int sentCount;
	integer seed = 32'h1c81;
	string testName = "reset";

	scoreVec_t headScores;
	classIdx_t headClass;
	int headCycle;

	mlpTop mlpTop_i (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.features (features),
		.outValid (outValid),
		.scores   (scores),
		.classIdx (classIdx)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	// Requantize one neuron sum following the rectifier rule
	function automatic activation_t rectify(input int sum);
		int shifted;
		shifted = sum >>> `ACT_SHIFT;
		if (sum < 0)
			return '0;
		else if (shifted > 127)
			return 8'sd127;
		else
			return activation_t'(shifted);
	endfunction

	function automatic void modelVector(input featureVec_t f, output scoreVec_t s,
		output classIdx_t c);
		hiddenVec_t h;
		int sum;
		activation_t best;
		for (int n = 0; n < `NUM_HIDDEN; n++)
		begin
			sum = int'(HIDDEN_BIAS[n]);
			for (int i = 0; i < `NUM_INPUTS; i++)
				sum = sum + int'(f[i]) * int'(HIDDEN_WEIGHTS[n][i]);
			h[n] = rectify(sum);
		end
		for (int o = 0; o < `NUM_OUTPUTS; o++)
		begin
			sum = int'(OUTPUT_BIAS[o]);
			for (int n = 0; n < `NUM_HIDDEN; n++)
				sum = sum + int'(h[n]) * int'(OUTPUT_WEIGHTS[o][n]);
			s[o] = rectify(sum);
		end
		c = '0;
		best = s[0];
		for (int o = 1; o < `NUM_OUTPUTS; o++)
		begin
			if (s[o] > best) // Ties leave the lower index in place
			begin
				best = s[o];
				c = classIdx_t'(o);
			end
		end
	endfunction

	task automatic makeRandomVector(output featureVec_t v);
		for (int i = 0; i < `NUM_INPUTS; i++)
			v[i] = activation_t'($random(seed));
	endtask

	task automatic sendVector(input featureVec_t f);
		scoreVec_t s;
		classIdx_t c;
		@(posedge clk);
		#1;
		inValid = 1'b1;
		features = f;
		modelVector(f, s, c);
		expScoresQ.push_back(s);
		expClassQ.push_back(c);
		expCycleQ.push_back(cycleCount + LATENCY); // Count of the edge that raises outValid
		sentCount++;
	endtask

	task automatic idleCycles(input int n);
		featureVec_t junk;
		repeat (n)
		begin
			@(posedge clk);
			#1;
			makeRandomVector(junk);
			inValid = 1'b0;
			features = junk; // The datapath must ignore data without a strobe
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errorCount;
		pulseCount = 0;
		sentCount = 0;
	endtask

	task automatic reportTest();
		if (errorCount == testErrors)
		begin
			passCount++;
			$display("Test %s: PASS", testName);
		end
		else
		begin
			failCount++;
			$display("Test %s: FAIL with %0d errors", testName, errorCount - testErrors);
		end
	endtask

	// Drains the pipeline, waits for stray strobes, then checks the result count
	task automatic endTest();
		idleCycles(1);
		while (expCycleQ.size() != 0)
			@(posedge clk);
		repeat (LATENCY + 3) @(posedge clk);
		#1;
		assert (pulseCount == sentCount)
		else
		begin
			$display("** Error [%s] result count expected %0d actual %0d", testName,
				sentCount, pulseCount);
			errorCount++;
		end
		reportTest();
	endtask

	task automatic checkIdleOutputs();
		assert (outValid == 1'b0 && scores == '0 && classIdx == '0)
		else
		begin
			$display("** Error [%s] outputs expected 0/000000/0 actual %0b/%h/%0d", testName,
				outValid, scores, classIdx);
			errorCount++;
		end
	endtask

	task automatic resetTest();
		startTest("reset");
		repeat (8)
		begin
			@(posedge clk);
			#1;
			checkIdleOutputs();
		end
		reset = 1'b0;
		repeat (3)
		begin
			@(posedge clk);
			#1;
			checkIdleOutputs();
		end
		reportTest();
	endtask

	task automatic singleVectorTest();
		featureVec_t v;
		startTest("single latency");
		v = {8'sd10, -8'sd20, 8'sd30, -8'sd40, 8'sd50, -8'sd60, 8'sd70, -8'sd80,
			8'sd90, -8'sd100, 8'sd110, -8'sd120, 8'sd5, -8'sd5, 8'sd1};
		sendVector(v);
		endTest();
	endtask

	task automatic rectifierTest();
		startTest("rectifier and clamp");
		sendVector({`NUM_INPUTS{8'sd127}}); // Saturates the clamp
		sendVector({`NUM_INPUTS{-8'sd128}}); // Drives every hidden sum negative
		sendVector('0); // Bias only
		endTest();
	endtask

	task automatic tieTest();
		scoreVec_t s;
		classIdx_t c;
		startTest("argmax tie");
		modelVector({`NUM_INPUTS{-8'sd128}}, s, c);
		assert (s[0] == s[1] && s[1] == s[2])
		else
		begin
			$display("Test %s: the tie vector does not give equal scores", testName);
			errorCount++;
		end
		sendVector({`NUM_INPUTS{-8'sd128}});
		sendVector('0);
		endTest();
	endtask

	task automatic streamTest();
		featureVec_t v;
		startTest("streaming");
		repeat (20)
		begin
			makeRandomVector(v);
			sendVector(v);
		end
		endTest();
	endtask

	task automatic gappedTest();
		featureVec_t v;
		int gap;
		startTest("gapped input");
		repeat (10)
		begin
			makeRandomVector(v);
			sendVector(v);
			gap = $random(seed) & 3;
			idleCycles(gap);
		end
		endTest();
	endtask

	// Every result is compared with the oldest outstanding prediction
	always @(negedge clk)
	begin
		if (!reset && outValid)
		begin
			pulseCount++;
			assert (expCycleQ.size() != 0)
			else
			begin
				$display("Test %s: outValid was high at cycle %0d with no result pending",
					testName, cycleCount);
				errorCount++;
			end
			if (expCycleQ.size() != 0)
			begin
				headScores = expScoresQ.pop_front();
				headClass = expClassQ.pop_front();
				headCycle = expCycleQ.pop_front();
				assert (cycleCount == headCycle)
				else
				begin
					$display("** Error [%s] result cycle expected %0d actual %0d", testName,
						headCycle, cycleCount);
					errorCount++;
				end
				assert (scores == headScores)
				else
				begin
					$display("** Error [%s] scores expected %h actual %h", testName,
						headScores, scores);
					errorCount++;
				end
				assert (classIdx == headClass)
				else
				begin
					$display("** Error [%s] class expected %0d actual %0d", testName,
						headClass, classIdx);
					errorCount++;
				end
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		features = '0;
		resetTest();
		singleVectorTest();
		rectifierTest();
		tieTest();
		streamTest();
		gappedTest();
		$display("Tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount,
			errorCount);
		if (failCount == 0 && errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
